// ==== src/periph_pkg.sv ====
/*
 * Shared definitions for the peripheral subsystem: address map, register
 * offsets, bus enums and the request/command structs used by RTL and testbench.
 */
`default_nettype none

package periph_pkg;

    // ----------------------------------------------------------------------
    // Bus widths and address map
    // ----------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int OFFS_W = 4;                      // Offset from addr[3:0]

    localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] UART_BASE = 32'h4000_1000;

    // GPIO register offsets
    localparam logic [OFFS_W-1:0] GPIO_OUT    = 4'h0;
    localparam logic [OFFS_W-1:0] GPIO_OE     = 4'h4;
    localparam logic [OFFS_W-1:0] GPIO_IN     = 4'h8;

    // UART register offsets
    localparam logic [OFFS_W-1:0] UART_TXDATA = 4'h0;
    localparam logic [OFFS_W-1:0] UART_STATUS = 4'h4;   // [0] tx busy, [1] rx valid
    localparam logic [OFFS_W-1:0] UART_RXDATA = 4'h8;

    // ----------------------------------------------------------------------
    // Enums and structs
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {IDLE, BUSY, NONSEQ, SEQ} htrans_e;

    typedef enum logic [2:0] {BYTE = 3'b000, HALF = 3'b001, WORD = 3'b010} hsize_e;

    typedef enum logic [1:0] {SEL_NONE, SEL_GPIO, SEL_UART} slave_sel_e;

    // Address phase, 38 bits
    typedef struct packed {
        logic [ADDR_W-1:0] haddr;
        htrans_e           htrans;
        hsize_e            hsize;
        logic              hwrite;
    } ahb_req_t;

    // Data-phase command to one slave, 10 bits
    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [OFFS_W-1:0] offs;
        logic [3:0]        be;
    } bus_cmd_t;

endpackage

`default_nettype wire

// ==== src/ahb_decoder.sv ====
/*
 * AHB-Lite address decoder. Registers the address phase, steers a data-phase
 * command to the selected slave and returns that slave's read word.
 */
`timescale 1ns/1ns
`default_nettype none

module ahb_decoder
(
    input  wire logic                          clk,
    input  wire logic                          RSTn,
    input  wire periph_pkg::ahb_req_t          i_req,
    input  wire logic [periph_pkg::DATA_W-1:0] i_gpio_rdata,
    input  wire logic [periph_pkg::DATA_W-1:0] i_uart_rdata,
    output periph_pkg::bus_cmd_t               o_gpio_cmd,
    output periph_pkg::bus_cmd_t               o_uart_cmd,
    output logic [periph_pkg::DATA_W-1:0]      o_hrdata
);
    import periph_pkg::*;

    localparam int PAGE_LSB = 12;                   // Slaves decode on addr[31:12]

    logic       xfer;
    slave_sel_e sel_d, sel_q;
    bus_cmd_t   cmd_d, cmd_q;

    assign xfer = (i_req.htrans == NONSEQ) || (i_req.htrans == SEQ);

    always_comb
    begin
        if (i_req.haddr[ADDR_W-1:PAGE_LSB] == GPIO_BASE[ADDR_W-1:PAGE_LSB])
            sel_d = SEL_GPIO;
        else if (i_req.haddr[ADDR_W-1:PAGE_LSB] == UART_BASE[ADDR_W-1:PAGE_LSB])
            sel_d = SEL_UART;
        else
            sel_d = SEL_NONE;
    end

    always_comb
    begin
        cmd_d.wr   = xfer & i_req.hwrite;
        cmd_d.rd   = xfer & ~i_req.hwrite;
        cmd_d.offs = {i_req.haddr[3:2], 2'b00};     // Word offset, lane goes to be
        case (i_req.hsize)
            BYTE:    cmd_d.be = 4'b0001 << i_req.haddr[1:0];
            HALF:    cmd_d.be = i_req.haddr[1] ? 4'b1100 : 4'b0011;
            default: cmd_d.be = 4'b1111;
        endcase
    end

    // Address phase captured here, command live in the next cycle
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            sel_q <= SEL_NONE;
            cmd_q <= '0;
        end
        else
        begin
            sel_q <= xfer ? sel_d : SEL_NONE;
            cmd_q <= cmd_d;
        end
    end

    assign o_gpio_cmd = (sel_q == SEL_GPIO) ? cmd_q : '0;
    assign o_uart_cmd = (sel_q == SEL_UART) ? cmd_q : '0;

    always_comb
    begin
        case (sel_q)
            SEL_GPIO: o_hrdata = i_gpio_rdata;
            SEL_UART: o_hrdata = i_uart_rdata;
            default:  o_hrdata = '0;                // Unmapped reads as zero
        endcase
    end

    // Only one slave sees a command, the one whose page was addressed
    a_one_slave: assert property (@(posedge clk) disable iff (!RSTn)
        (o_gpio_cmd.wr || o_gpio_cmd.rd) |->
            !(o_uart_cmd.wr || o_uart_cmd.rd) &&
            $past(i_req.haddr[ADDR_W-1:PAGE_LSB]) == GPIO_BASE[ADDR_W-1:PAGE_LSB])
        else $error("Decoder drove the GPIO command for another page or both commands");

    a_uart_page: assert property (@(posedge clk) disable iff (!RSTn)
        (o_uart_cmd.wr || o_uart_cmd.rd) |->
            $past(i_req.haddr[ADDR_W-1:PAGE_LSB]) == UART_BASE[ADDR_W-1:PAGE_LSB])
        else $error("Decoder drove the UART command for another page");

endmodule

`default_nettype wire

// ==== src/ahb_gpio.sv ====
/*
 * GPIO register block behind the decoder. Output data and output enable are
 * written per byte lane; input pins are synchronized before they are read.
 */
`timescale 1ns/1ns
`default_nettype none

module ahb_gpio
(
    input  wire logic                          clk,
    input  wire logic                          RSTn,
    input  wire periph_pkg::bus_cmd_t          i_cmd,
    input  wire logic [periph_pkg::DATA_W-1:0] i_hwdata,
    input  wire logic [periph_pkg::DATA_W-1:0] i_gpio_in,
    output logic [periph_pkg::DATA_W-1:0]      o_rdata,
    output logic [periph_pkg::DATA_W-1:0]      o_gpio_out,
    output logic [periph_pkg::DATA_W-1:0]      o_gpio_oe
);
    import periph_pkg::*;

    logic [DATA_W-1:0] in_meta;
    logic [DATA_W-1:0] in_sync;

    // Replace only the enabled byte lanes
    function automatic logic [DATA_W-1:0] lane_merge(input logic [DATA_W-1:0] old_v,
                                                     input logic [DATA_W-1:0] new_v,
                                                     input logic [3:0]        be);
        logic [DATA_W-1:0] res;
        res = old_v;
        for (int i = 0; i < 4; i++)
        begin
            if (be[i])
                res[8*i +: 8] = new_v[8*i +: 8];
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            o_gpio_out <= '0;
            o_gpio_oe  <= '0;
        end
        else if (i_cmd.wr)
        begin
            if (i_cmd.offs == GPIO_OUT)
                o_gpio_out <= lane_merge(o_gpio_out, i_hwdata, i_cmd.be);
            if (i_cmd.offs == GPIO_OE)
                o_gpio_oe  <= lane_merge(o_gpio_oe, i_hwdata, i_cmd.be);
        end
    end

    // Two-flop synchronizer on the pins
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            in_meta <= '0;
            in_sync <= '0;
        end
        else
        begin
            in_meta <= i_gpio_in;
            in_sync <= in_meta;
        end
    end

    always_comb
    begin
        o_rdata = '0;
        if (i_cmd.rd)
        begin
            case (i_cmd.offs)
                GPIO_OUT: o_rdata = o_gpio_out;
                GPIO_OE:  o_rdata = o_gpio_oe;
                GPIO_IN:  o_rdata = in_sync;
                default:  o_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
/*
 * 8N1 serial transmitter. A start strobe loads the byte and shifts out
 * start bit, data LSB first and stop bit, each CLKS_PER_BIT cycles long.
 */
`timescale 1ns/1ns
`default_nettype none

module uart_tx
#(
    parameter int CLKS_PER_BIT = 8
)
(
    input  wire logic       clk,
    input  wire logic       RSTn,
    input  wire logic       i_start,
    input  wire logic [7:0] i_data,
    output logic            o_txd,
    output logic            o_busy
);
    localparam int               CNT_W   = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_e;

    tx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             bit_end;

    assign bit_end = (cnt == CNT_MAX);
    assign o_busy  = (state != IDLE);

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state   <= IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_txd   <= 1'b1;                        // Line idles high
        end
        else
        begin
            if (state == IDLE || bit_end)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
            case (state)
                IDLE:
                    if (i_start)
                    begin
                        state <= START;
                        o_txd <= 1'b0;
                    end
                START:
                    if (bit_end)
                    begin
                        state   <= DATA;
                        bit_idx <= '0;
                        o_txd   <= shift[0];
                    end
                DATA:
                    if (bit_end)
                    begin
                        if (bit_idx == 3'd7)
                        begin
                            state <= STOP;
                            o_txd <= 1'b1;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                            o_txd   <= shift[0];
                        end
                    end
                STOP:
                    if (bit_end)
                        state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Next data bit always sits in shift[0]
    always_ff @(posedge clk)
    begin
        if (state == IDLE)
        begin
            if (i_start)
                shift <= i_data;
        end
        else if (bit_end)
            shift <= {1'b0, shift[7:1]};
    end

    // Register block must hold off until the frame is done
    a_no_start_busy: assert property (@(posedge clk) disable iff (!RSTn)
        i_start |-> !o_busy)
        else $error("TX start while busy");

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
/*
 * 8N1 serial receiver. The line is synchronized, the start bit confirmed at
 * its middle, and each later bit sampled mid-period; bad stop bits drop the frame.
 */
`timescale 1ns/1ns
`default_nettype none

module uart_rx
#(
    parameter int CLKS_PER_BIT = 8
)
(
    input  wire logic  clk,
    input  wire logic  RSTn,
    input  wire logic  i_rxd,
    output logic       o_valid,
    output logic [7:0] o_data
);
    localparam int               CNT_W   = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             rxd_meta;
    logic             rxd_s;
    logic             bit_end;

    assign bit_end = (cnt == CNT_MAX);

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
        end
        else
        begin
            rxd_meta <= i_rxd;
            rxd_s    <= rxd_meta;
        end
    end

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state   <= IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= 1'b0;
            case (state)
                IDLE:
                begin
                    cnt <= '0;
                    if (!rxd_s)
                        state <= START;             // Falling edge seen
                end
                START:
                    if (cnt == CNT_MID)
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? IDLE : DATA;     // Glitch goes back to idle
                    end
                    else
                        cnt <= cnt + 1'b1;
                DATA:
                    if (bit_end)
                    begin
                        cnt <= '0;
                        if (bit_idx == 3'd7)
                            state <= STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                    else
                        cnt <= cnt + 1'b1;
                STOP:
                    if (bit_end)
                    begin
                        cnt     <= '0;
                        state   <= IDLE;
                        o_valid <= rxd_s;           // Low stop bit discards frame
                    end
                    else
                        cnt <= cnt + 1'b1;
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk)
    begin
        if (state == DATA && bit_end)
            o_data <= {rxd_s, o_data[7:1]};
    end

endmodule

`default_nettype wire

// ==== src/ahb_uart.sv ====
/*
 * UART register block. TXDATA writes start the transmitter, received bytes
 * are buffered with a valid flag that drives the interrupt until read.
 */
`timescale 1ns/1ns
`default_nettype none

module ahb_uart
#(
    parameter int CLKS_PER_BIT = 8
)
(
    input  wire logic                          clk,
    input  wire logic                          RSTn,
    input  wire periph_pkg::bus_cmd_t          i_cmd,
    input  wire logic [periph_pkg::DATA_W-1:0] i_hwdata,
    input  wire logic                          i_rxd,
    output logic [periph_pkg::DATA_W-1:0]      o_rdata,
    output logic                               o_txd,
    output logic                               o_irq
);
    import periph_pkg::*;

    logic       tx_wr;
    logic       tx_busy;
    logic       tx_busy_all;
    logic       tx_start_q;
    logic [7:0] tx_data_q;
    logic       rx_pulse;
    logic [7:0] rx_byte;
    logic [7:0] rx_buf;
    logic       rx_valid;
    logic       rx_rd;

    assign tx_wr       = i_cmd.wr & i_cmd.be[0] & (i_cmd.offs == UART_TXDATA);
    assign rx_rd       = i_cmd.rd & (i_cmd.offs == UART_RXDATA);
    assign tx_busy_all = tx_busy | tx_start_q;      // Covers the strobe cycle too

    // ----------------------------------------------------------------------
    // Control flags
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            tx_start_q <= 1'b0;
            rx_valid   <= 1'b0;
        end
        else
        begin
            tx_start_q <= tx_wr & ~tx_busy_all;     // Writes while busy dropped
            if (rx_pulse)
                rx_valid <= 1'b1;                   // New byte wins over a read
            else if (rx_rd)
                rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_wr && !tx_busy_all)
            tx_data_q <= i_hwdata[7:0];
        if (rx_pulse)
            rx_buf <= rx_byte;                      // Overwrites an unread byte
    end

    assign o_irq = rx_valid;

    always_comb
    begin
        o_rdata = '0;
        if (i_cmd.rd)
        begin
            case (i_cmd.offs)
                UART_STATUS: o_rdata = {{(DATA_W-2){1'b0}}, rx_valid, tx_busy_all};
                UART_RXDATA: o_rdata = {{(DATA_W-8){1'b0}}, rx_buf};
                default:     o_rdata = '0;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Serial engines
    // ----------------------------------------------------------------------
    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx
    (
        .clk     (clk),
        .RSTn    (RSTn),
        .i_start (tx_start_q),
        .i_data  (tx_data_q),
        .o_txd   (o_txd),
        .o_busy  (tx_busy)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx
    (
        .clk     (clk),
        .RSTn    (RSTn),
        .i_rxd   (i_rxd),
        .o_valid (rx_pulse),
        .o_data  (rx_byte)
    );

endmodule

`default_nettype wire

// ==== src/periph_subsystem.sv ====
/*
 * Top level of the AHB-Lite peripheral subsystem. Connects the address
 * decoder to the GPIO and UART slaves; the bus master sits outside.
 */
`timescale 1ns/1ns
`default_nettype none

module periph_subsystem
#(
    parameter int CLKS_PER_BIT = 8
)
(
    input  wire logic                          clk,
    input  wire logic                          RSTn,
    input  wire periph_pkg::ahb_req_t          i_req,
    input  wire logic [periph_pkg::DATA_W-1:0] i_hwdata,
    input  wire logic [periph_pkg::DATA_W-1:0] i_gpio_in,
    input  wire logic                          i_rxd,
    output logic [periph_pkg::DATA_W-1:0]      o_hrdata,
    output logic [periph_pkg::DATA_W-1:0]      o_gpio_out,
    output logic [periph_pkg::DATA_W-1:0]      o_gpio_oe,
    output logic                               o_txd,
    output logic                               o_uart_irq
);
    import periph_pkg::*;

    // ----------------------------------------------------------------------
    // Decoder to slave wiring
    // ----------------------------------------------------------------------
    bus_cmd_t          gpio_cmd;
    bus_cmd_t          uart_cmd;
    logic [DATA_W-1:0] gpio_rdata;
    logic [DATA_W-1:0] uart_rdata;

    ahb_decoder u_decoder
    (
        .clk          (clk),
        .RSTn         (RSTn),
        .i_req        (i_req),
        .i_gpio_rdata (gpio_rdata),
        .i_uart_rdata (uart_rdata),
        .o_gpio_cmd   (gpio_cmd),
        .o_uart_cmd   (uart_cmd),
        .o_hrdata     (o_hrdata)
    );

    ahb_gpio u_gpio
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_cmd      (gpio_cmd),
        .i_hwdata   (i_hwdata),
        .i_gpio_in  (i_gpio_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (o_gpio_out),
        .o_gpio_oe  (o_gpio_oe)
    );

    ahb_uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart
    (
        .clk      (clk),
        .RSTn     (RSTn),
        .i_cmd    (uart_cmd),
        .i_hwdata (i_hwdata),
        .i_rxd    (i_rxd),
        .o_rdata  (uart_rdata),
        .o_txd    (o_txd),
        .o_irq    (o_uart_irq)
    );

endmodule

`default_nettype wire

// ==== dv/periph_checker.sv ====
/*
 * Testbench checker for the peripheral subsystem. Compares posted read and
 * pin expectations, and decodes every TXD frame against a queue of bytes.
 */
`timescale 1ns/1ns
`default_nettype none

module periph_checker
#(
    parameter int CLKS_PER_BIT = 8,
    parameter int NAME_W       = 96
)
(
    input  wire logic              clk,
    input  wire logic              i_chk_stb,   // One cycle, sampled at the next edge
    input  wire logic [2:0]        i_chk_kind,  // 0 hrdata, 1 out, 2 oe, 3 txd, 4 irq
    input  wire logic [NAME_W-1:0] i_chk_name,
    input  wire logic [31:0]       i_chk_exp,
    input  wire logic              i_tx_push,
    input  wire logic [7:0]        i_tx_byte,
    input  wire logic [31:0]       i_hrdata,
    input  wire logic [31:0]       i_gpio_out,
    input  wire logic [31:0]       i_gpio_oe,
    input  wire logic              i_txd,
    input  wire logic              i_irq,
    output int                     o_errors,
    output logic                   o_idle
);
    int                err_cnt = 0;
    int                pending = 0;
    logic              frame_active = 1'b0;
    logic [7:0]        exp_q[$];
    logic [NAME_W-1:0] name_q[$];

    assign o_errors = err_cnt;
    assign o_idle   = (pending == 0) && !frame_active;

    // ----------------------------------------------------------------------
    // Posted value checks
    // ----------------------------------------------------------------------
    always @(posedge clk)
    begin : value_check
        logic [31:0] act;
        if (i_chk_stb)
        begin
            case (i_chk_kind)
                3'd0:    act = i_hrdata;            // Data phase of a read
                3'd1:    act = i_gpio_out;
                3'd2:    act = i_gpio_oe;
                3'd3:    act = {31'b0, i_txd};
                default: act = {31'b0, i_irq};
            endcase
            if (act !== i_chk_exp)
            begin
                $display("error %0s: expected %h, got %h", i_chk_name, i_chk_exp, act);
                err_cnt++;
            end
        end
        if (i_tx_push)
        begin
            exp_q.push_back(i_tx_byte);
            name_q.push_back(i_chk_name);
            pending++;
        end
    end

    // ----------------------------------------------------------------------
    // TXD frame decoder, samples each bit at its middle
    // ----------------------------------------------------------------------
    always
    begin : txd_decode
        logic [7:0]        got;
        logic [7:0]        exp_b;
        logic [NAME_W-1:0] exp_name;
        @(negedge i_txd);
        frame_active = 1'b1;
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        if (i_txd !== 1'b0)
        begin
            $display("TXD start bit was not low at its middle");
            err_cnt++;
        end
        for (int i = 0; i < 8; i++)
        begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            got[i] = i_txd;                         // LSB first
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        if (i_txd !== 1'b1)
        begin
            $display("TXD stop bit was low for frame %h", got);
            err_cnt++;
        end
        if (exp_q.size() == 0)
        begin
            $display("TXD sent frame %h while no byte was expected", got);
            err_cnt++;
        end
        else
        begin
            exp_b    = exp_q.pop_front();
            exp_name = name_q.pop_front();
            pending--;
            if (got !== exp_b)
            begin
                $display("error %0s: expected %h, got %h", exp_name, exp_b, got);
                err_cnt++;
            end
        end
        frame_active = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/tb_periph.sv ====
/*
 * Testbench for the peripheral subsystem. Acts as AHB-Lite master and serial
 * peer, running the operations listed in dv/periph_testdata.txt.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_periph;
    import periph_pkg::*;

    localparam int          CLKS_PER_BIT = 8;
    localparam int          NAME_W       = 96;    // Up to 12 characters
    localparam int          RESET_CYCLES = 8;
    localparam int          POLL_MAX     = 100;
    localparam int          WAIT_MAX     = 200;
    localparam int          WDOG_CYCLES  = 20000;
    localparam logic [31:0] SEED         = 32'ha2cd2de0;
    localparam logic [31:0] STATUS_ADDR  = UART_BASE + 32'(UART_STATUS);

    logic              clk = 1'b0;
    logic              RSTn;
    ahb_req_t          i_req;
    logic [31:0]       i_hwdata;
    logic [31:0]       i_gpio_in;
    logic              i_rxd;
    logic [31:0]       o_hrdata;
    logic [31:0]       o_gpio_out;
    logic [31:0]       o_gpio_oe;
    logic              o_txd;
    logic              o_uart_irq;
    logic              chk_stb;
    logic [2:0]        chk_kind;
    logic [NAME_W-1:0] chk_name;
    logic [31:0]       chk_exp;
    logic              tx_push;
    logic [7:0]        tx_byte;
    int                chk_errors;
    logic              chk_idle;
    int                tb_errors = 0;

    always #2 clk = ~clk;                           // 4 ns period

    periph_subsystem #(.CLKS_PER_BIT(CLKS_PER_BIT)) periph_subsystem_inst
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_req      (i_req),
        .i_hwdata   (i_hwdata),
        .i_gpio_in  (i_gpio_in),
        .i_rxd      (i_rxd),
        .o_hrdata   (o_hrdata),
        .o_gpio_out (o_gpio_out),
        .o_gpio_oe  (o_gpio_oe),
        .o_txd      (o_txd),
        .o_uart_irq (o_uart_irq)
    );

    periph_checker #(.CLKS_PER_BIT(CLKS_PER_BIT), .NAME_W(NAME_W)) periph_checker_inst
    (
        .clk        (clk),
        .i_chk_stb  (chk_stb),
        .i_chk_kind (chk_kind),
        .i_chk_name (chk_name),
        .i_chk_exp  (chk_exp),
        .i_tx_push  (tx_push),
        .i_tx_byte  (tx_byte),
        .i_hrdata   (o_hrdata),
        .i_gpio_out (o_gpio_out),
        .i_gpio_oe  (o_gpio_oe),
        .i_txd      (o_txd),
        .i_irq      (o_uart_irq),
        .o_errors   (chk_errors),
        .o_idle     (chk_idle)
    );

    // ----------------------------------------------------------------------
    // Bus master and pin drivers, all entered and left at edge + 1 ns
    // ----------------------------------------------------------------------
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input hsize_e size);
        i_req.haddr  = addr;
        i_req.htrans = NONSEQ;
        i_req.hsize  = size;
        i_req.hwrite = 1'b1;
        @(posedge clk);
        #1;
        i_req    = '0;
        i_hwdata = data;                            // Data phase
        @(posedge clk);
        #1;
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp,
                            input logic [NAME_W-1:0] name, input logic check,
                            output logic [31:0] data);
        i_req.haddr  = addr;
        i_req.htrans = NONSEQ;
        i_req.hsize  = WORD;
        i_req.hwrite = 1'b0;
        @(posedge clk);
        #1;
        i_req    = '0;
        chk_stb  = check;
        chk_kind = 3'd0;
        chk_name = name;
        chk_exp  = exp;
        #1 data  = o_hrdata;                        // Mid data phase
        @(posedge clk);
        #1;
        chk_stb = 1'b0;
    endtask

    task automatic post_check(input logic [2:0] kind, input logic [NAME_W-1:0] name,
                              input logic [31:0] exp);
        chk_stb  = 1'b1;
        chk_kind = kind;
        chk_name = name;
        chk_exp  = exp;
        @(posedge clk);
        #1;
        chk_stb = 1'b0;
    endtask

    task automatic expect_tx(input logic [7:0] data, input logic [NAME_W-1:0] name);
        tx_push  = 1'b1;
        tx_byte  = data;
        chk_name = name;
        @(posedge clk);
        #1;
        tx_push = 1'b0;
    endtask

    task automatic send_serial(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};                 // Stop, data, start
        for (int i = 0; i < 10; i++)
        begin
            i_rxd = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_irq(input logic level, input logic [NAME_W-1:0] name);
        int n;
        n = 0;
        while (o_uart_irq !== level && n < WAIT_MAX)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        post_check(3'd4, name, {31'b0, level});
    endtask

    task automatic poll_tx_idle(input logic [NAME_W-1:0] name);
        int          n;
        logic [31:0] st;
        n  = 0;
        st = 32'h1;
        while (st[0] === 1'b1 && n < POLL_MAX)
        begin
            bus_read(STATUS_ADDR, 32'h0, name, 1'b0, st);
            n++;
        end
        if (st[0] !== 1'b0)
        begin
            $display("timeout in %0s: UART status stayed busy", name);
            tb_errors++;
        end
        else if (!chk_idle)
        begin
            $display("%0s: UART status went idle before the TXD frame was done", name);
            tb_errors++;
        end
    endtask

    task automatic run_op(input logic [31:0] op, input logic [NAME_W-1:0] name,
                          input logic [31:0] a, input logic [31:0] b);
        logic [31:0] unused;
        case (op)
            "wr":    bus_write(a, b, WORD);
            "wrb":   bus_write(a, b, BYTE);
            "rd":    bus_read(a, b, name, 1'b1, unused);
            "pin":   post_check(a[2:0], name, b);
            "irq":   wait_irq(b[0], name);
            "txe":   expect_tx(a[7:0], name);
            "rxs":   send_serial(a[7:0]);
            "poll":  poll_tx_idle(name);
            "gin":
            begin
                i_gpio_in = a;
                repeat (3) @(posedge clk);          // Two sync flops and margin
                #1;
            end
            default:
            begin
                $display("unknown operation in data file for test %0s", name);
                tb_errors++;
            end
        endcase
    endtask

    // ----------------------------------------------------------------------
    // Sequencing
    // ----------------------------------------------------------------------
    initial
    begin : main
        int                fd;
        int                n;
        int                seed_val;
        int                total;
        logic [31:0]       op;
        logic [NAME_W-1:0] name;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [1023:0]     skip;
        seed_val  = $urandom(SEED);
        RSTn      = 1'b0;
        i_req     = '0;
        i_hwdata  = '0;
        i_gpio_in = '0;
        i_rxd     = 1'b1;
        chk_stb   = 1'b0;
        chk_kind  = '0;
        chk_name  = '0;
        chk_exp   = '0;
        tx_push   = 1'b0;
        tx_byte   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 RSTn = 1'b1;
        @(posedge clk);
        #1;
        fd = $fopen("dv/periph_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the data file dv/periph_testdata.txt");
            tb_errors++;
        end
        else
        begin
            while ($fscanf(fd, "%s", op) == 1)
            begin
                if (op == "#")
                    n = $fgets(skip, fd);           // Comment line
                else
                begin
                    n = $fscanf(fd, "%s %h %h", name, a, b);
                    run_op(op, name, a, b);
                    repeat ($urandom % 3)
                    begin
                        @(posedge clk);
                        #1;
                    end
                end
            end
            $fclose(fd);
        end
        n = 0;
        while (!chk_idle && n < WAIT_MAX)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!chk_idle)
        begin
            $display("timeout: expected TXD frames never finished");
            tb_errors++;
        end
        total = tb_errors + chk_errors;
        $display("errors: %0d total, %0d in checker, %0d in testbench",
                 total, chk_errors, tb_errors);
        if (total == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Overall limit on run time
    initial
    begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: simulation ran past its cycle limit");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/periph_testdata.txt ====
# op test addr_or_value data_or_expected (hex), pin kind 1 out 2 oe 3 txd
# ops: wr wrb rd pin irq txe rxs poll gin
rd   rst_out   40000000 00000000
rd   rst_oe    40000004 00000000
rd   rst_stat  40001004 00000000
pin  rst_txd   00000003 00000001
irq  rst_irq   00000000 00000000
wr   out_word  40000000 12345678
pin  out_pin   00000001 12345678
rd   out_rd    40000000 12345678
wr   oe_word   40000004 0000ffff
wrb  oe_byte   40000007 a5000000
pin  oe_pin    00000002 a500ffff
rd   oe_rd     40000004 a500ffff
wrb  out_byte  40000002 00ab0000
rd   out_brd   40000000 12ab5678
gin  in_drive  c0ffee42 00000000
rd   in_rd     40000008 c0ffee42
txe  tx_frame  0000003c 00000000
wr   tx_send   40001000 0000003c
rd   tx_busy   40001004 00000001
wr   tx_drop   40001000 000000c3
poll tx_poll   00000000 00000000
rd   tx_idle   40001004 00000000
rxs  rx_send   0000009d 00000000
irq  rx_irq    00000000 00000001
rd   rx_stat   40001004 00000002
rd   rx_data   40001008 0000009d
irq  rx_clear  00000000 00000000
rd   map_none  40002000 00000000
rd   map_offs  4000000c 00000000
rd   map_uoff  4000100c 00000000
wr   map_wr    40003000 ffffffff
wr   map_wroff 4000000c ffffffff
rd   map_keep  40000000 12ab5678

// ==== filelist.f ====
src/periph_pkg.sv
src/ahb_decoder.sv
src/ahb_gpio.sv
src/uart_tx.sv
src/uart_rx.sv
src/ahb_uart.sv
src/periph_subsystem.sv
dv/periph_checker.sv
dv/tb_periph.sv
